// ==== dqmFramer_defines.svh ====
`ifndef DQM_FRAMER_DEFINES_SVH
`define DQM_FRAMER_DEFINES_SVH

// Frame header contents
`define DQM_SYNC_WORD 16'hEB90
`define DQM_VERSION 4'h1
`define DQM_HDR_BITS 48

// Configuration field widths
`define DQM_LEN_WIDTH 14
`define DQM_DIV_WIDTH 16

// Bits per ping or pong buffer, at least the largest payload length
`define DQM_FIFO_DEPTH 16384

`endif

// ==== dqmFramePkg.sv ====
`include "dqmFramer_defines.svh"

package dqmFramePkg;

    typedef struct packed {
        logic [15:0] sync;
        logic [11:0] reserved;
        logic [3:0]  version;
        logic [15:0] dqm;
    } dqmHeaderFieldsT;

    // Filled by field, sent MSB first as raw bits
    typedef union packed {
        logic [`DQM_HDR_BITS-1:0] raw;
        dqmHeaderFieldsT          fields;
    } dqmHeaderT;

    typedef struct packed {
        logic bitEn;
        logic bitVal;
    } payloadStreamT;

    typedef struct packed {
        logic bitEn;
        logic bitVal;
        logic startOfFrame;
    } serialStreamT;

    typedef enum logic {
        PING = 1'b0,
        PONG = 1'b1
    } bufSelT;

    typedef enum logic {
        WR_FLUSH,
        WR_WRITE
    } writerStateT;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_WAIT,
        SER_HEADER,
        SER_PAYLOAD
    } serStateT;

endpackage

// ==== dqmBusPkg.sv ====
`include "dqmFramer_defines.svh"

package dqmBusPkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    typedef struct packed {
        logic                      enable;
        logic [`DQM_LEN_WIDTH-1:0] payloadLength;
        logic [`DQM_DIV_WIDTH-1:0] clksPerBit;
        logic [15:0]               dqm;
    } cfgT;

    // Word addresses
    localparam logic [3:0] REG_CTRL    = 4'h0;
    localparam logic [3:0] REG_LENGTH  = 4'h1;
    localparam logic [3:0] REG_DIVIDER = 4'h2;
    localparam logic [3:0] REG_DQM     = 4'h3;
    localparam logic [3:0] REG_OVERRUN = 4'h4;

endpackage

// ==== dqmRegs.sv ====
`timescale 1ns/1ps
`include "dqmFramer_defines.svh"

module dqmRegs
    import dqmBusPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  wbReqT wbReq,
    output wbRspT wbRsp,
    input  logic  overrunPulse,
    output cfgT   cfg
);

    logic        ackReg;
    logic [31:0] datReg;
    logic        accept;
    logic [31:0] readData;
    logic [31:0] wrData;
    logic [15:0] overrunCount;

    function automatic logic [31:0] mergeBytes(input logic [31:0] oldVal,
                                               input logic [31:0] newVal,
                                               input logic [3:0]  byteSel);
        logic [31:0] result;
        for (int i = 0; i < 4; i++) begin
            result[8*i +: 8] = byteSel[i] ? newVal[8*i +: 8] : oldVal[8*i +: 8];
        end
        return result;
    endfunction

    // Ack low in between, so one ack per access
    assign accept = wbReq.cyc && wbReq.stb && !ackReg;
    assign wrData = mergeBytes(readData, wbReq.dat, wbReq.sel);
    assign wbRsp = '{ack: ackReg, dat: datReg};

    always_comb begin
        readData = '0;
        case (wbReq.adr)
            REG_CTRL:    readData[0] = cfg.enable;
            REG_LENGTH:  readData[`DQM_LEN_WIDTH-1:0] = cfg.payloadLength;
            REG_DIVIDER: readData[`DQM_DIV_WIDTH-1:0] = cfg.clksPerBit;
            REG_DQM:     readData[15:0] = cfg.dqm;
            REG_OVERRUN: readData[15:0] = overrunCount;
            default:     readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ackReg <= 1'b0;
            cfg <= '0;
            overrunCount <= '0;
        end else begin
            ackReg <= accept;
            if (overrunPulse && overrunCount != '1) begin
                overrunCount <= overrunCount + 1'b1;
            end
            if (accept && wbReq.we) begin
                case (wbReq.adr)
                    REG_CTRL:    cfg.enable <= wrData[0];
                    REG_LENGTH:  cfg.payloadLength <= wrData[`DQM_LEN_WIDTH-1:0];
                    REG_DIVIDER: cfg.clksPerBit <= wrData[`DQM_DIV_WIDTH-1:0];
                    REG_DQM:     cfg.dqm <= wrData[15:0];
                    // Any write clears the counter
                    REG_OVERRUN: overrunCount <= '0;
                    default:     ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            datReg <= readData;
        end
    end

endmodule

// ==== dqmPayloadWriter.sv ====
`timescale 1ns/1ps
`include "dqmFramer_defines.svh"

module dqmPayloadWriter
    import dqmFramePkg::*, dqmBusPkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  cfgT           cfg,
    input  payloadStreamT payloadIn,
    input  logic          pingEmpty,
    input  logic          pongEmpty,
    output payloadStreamT pingWr,
    output payloadStreamT pongWr,
    output logic          frameReady,
    output bufSelT        readSel,
    output logic          overrunPulse
);

    writerStateT               state;
    bufSelT                    writeSel;
    logic [`DQM_LEN_WIDTH-1:0] bitCount;
    logic [`DQM_LEN_WIDTH-1:0] lastIdx;
    logic                      nextEmpty;

    // Length zero counts as a one-bit frame
    assign lastIdx = (cfg.payloadLength == '0) ? '0 : cfg.payloadLength - 1'b1;
    assign nextEmpty = (writeSel == PING) ? pongEmpty : pingEmpty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WR_FLUSH;
            writeSel <= PING;
            bitCount <= '0;
            pingWr <= '0;
            pongWr <= '0;
            frameReady <= 1'b0;
            readSel <= PING;
            overrunPulse <= 1'b0;
        end else begin
            pingWr <= '0;
            pongWr <= '0;
            frameReady <= 1'b0;
            overrunPulse <= 1'b0;
            case (state)
                WR_FLUSH: begin
                    // Input bits are dropped until both buffers drain
                    if (cfg.enable && pingEmpty && pongEmpty) begin
                        state <= WR_WRITE;
                        writeSel <= PING;
                        bitCount <= '0;
                    end
                end
                WR_WRITE: begin
                    if (!cfg.enable) begin
                        state <= WR_FLUSH;
                    end else if (payloadIn.bitEn) begin
                        if (writeSel == PING) begin
                            pingWr <= payloadIn;
                        end else begin
                            pongWr <= payloadIn;
                        end
                        if (bitCount >= lastIdx) begin
                            bitCount <= '0;
                            frameReady <= 1'b1;
                            readSel <= writeSel;
                            writeSel <= (writeSel == PING) ? PONG : PING;
                            // Other buffer still being sent
                            if (!nextEmpty) begin
                                overrunPulse <= 1'b1;
                                state <= WR_FLUSH;
                            end
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                default: state <= WR_FLUSH;
            endcase
        end
    end

endmodule

// ==== dqmPingPongBuffer.sv ====
`timescale 1ns/1ps
`include "dqmFramer_defines.svh"

module dqmPingPongBuffer
    import dqmFramePkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  payloadStreamT pingWr,
    input  payloadStreamT pongWr,
    input  logic          pingRd,
    input  logic          pongRd,
    output logic          pingHead,
    output logic          pongHead,
    output logic          pingEmpty,
    output logic          pongEmpty
);

    localparam int fifoDepth = `DQM_FIFO_DEPTH;
    localparam int addrWidth = $clog2(fifoDepth);

    // Index 0 is ping, index 1 is pong
    payloadStreamT wr [2];
    logic          rd [2];
    logic          head [2];
    logic          empty [2];

    assign wr[0] = pingWr;
    assign wr[1] = pongWr;
    assign rd[0] = pingRd;
    assign rd[1] = pongRd;

    assign pingHead = head[0];
    assign pongHead = head[1];
    assign pingEmpty = empty[0];
    assign pongEmpty = empty[1];

    for (genvar b = 0; b < 2; b++) begin : gBuf
        logic                 memBits [fifoDepth];
        logic [addrWidth:0]   wrPtr;
        logic [addrWidth:0]   rdPtr;
        logic                 full;
        logic                 doWrite;
        logic                 doRead;

        // Extra pointer bit tells full from empty
        assign empty[b] = (wrPtr == rdPtr);
        assign full = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
                      (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);
        assign doWrite = wr[b].bitEn && !full;
        assign doRead = rd[b] && !empty[b];

        // Fall-through head bit
        assign head[b] = memBits[rdPtr[addrWidth-1:0]];

        always_ff @(posedge clk) begin
            if (reset || flush) begin
                wrPtr <= '0;
                rdPtr <= '0;
            end else begin
                if (doWrite) begin
                    wrPtr <= wrPtr + 1'b1;
                end
                if (doRead) begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (doWrite) begin
                memBits[wrPtr[addrWidth-1:0]] <= wr[b].bitVal;
            end
        end
    end

endmodule

// ==== dqmFrameSerializer.sv ====
`timescale 1ns/1ps
`include "dqmFramer_defines.svh"

module dqmFrameSerializer
    import dqmFramePkg::*, dqmBusPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  cfgT          cfg,
    input  logic         frameReady,
    input  bufSelT       readSel,
    input  logic         pingHead,
    input  logic         pongHead,
    input  logic         pingEmpty,
    input  logic         pongEmpty,
    output logic         pingRd,
    output logic         pongRd,
    output serialStreamT serialOut
);

    localparam int hdrBits = `DQM_HDR_BITS;

    serStateT                  state;
    logic [`DQM_DIV_WIDTH-1:0] divCount;
    logic                      tick;
    logic [`DQM_LEN_WIDTH-1:0] bitCount;
    logic [`DQM_LEN_WIDTH-1:0] lastIdx;
    dqmHeaderT                 freshHeader;
    dqmHeaderT                 headerSr;
    bufSelT                    curSel;
    bufSelT                    pendSel;
    bufSelT                    nextSel;
    logic                      pending;
    logic                      nextReady;
    logic                      curEmpty;
    logic                      curHead;
    logic                      bitTick;

    // One tick every clksPerBit+1 clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
        end else if (tick) begin
            divCount <= cfg.clksPerBit;
        end else begin
            divCount <= divCount - 1'b1;
        end
    end

    assign tick = (divCount == '0);

    // DQM is taken at the tick that sends the first header bit
    always_comb begin
        freshHeader.fields.sync = `DQM_SYNC_WORD;
        freshHeader.fields.reserved = '0;
        freshHeader.fields.version = `DQM_VERSION;
        freshHeader.fields.dqm = cfg.dqm;
    end

    assign lastIdx = (cfg.payloadLength == '0) ? '0 : cfg.payloadLength - 1'b1;
    assign curEmpty = (curSel == PING) ? pingEmpty : pongEmpty;
    assign curHead = (curSel == PING) ? pingHead : pongHead;
    assign bitTick = tick && !curEmpty;
    assign nextReady = pending || frameReady;
    assign nextSel = pending ? pendSel : readSel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SER_IDLE;
            bitCount <= '0;
            curSel <= PING;
            pendSel <= PING;
            pending <= 1'b0;
        end else begin
            // Hold a frame that completes while another is being sent
            if (frameReady) begin
                pending <= 1'b1;
                pendSel <= readSel;
            end
            if (state != SER_IDLE && curEmpty) begin
                // Buffer was flushed, abandon the frame
                state <= SER_IDLE;
                pending <= 1'b0;
            end else begin
                case (state)
                    SER_IDLE: begin
                        if (nextReady) begin
                            state <= SER_WAIT;
                            curSel <= nextSel;
                            pending <= pending && frameReady;
                        end
                    end
                    SER_WAIT: begin
                        if (bitTick) begin
                            state <= SER_HEADER;
                            bitCount <= `DQM_LEN_WIDTH'(hdrBits - 2);
                        end
                    end
                    SER_HEADER: begin
                        if (bitTick) begin
                            if (bitCount == '0) begin
                                state <= SER_PAYLOAD;
                                bitCount <= lastIdx;
                            end else begin
                                bitCount <= bitCount - 1'b1;
                            end
                        end
                    end
                    SER_PAYLOAD: begin
                        if (bitTick) begin
                            if (bitCount != '0) begin
                                bitCount <= bitCount - 1'b1;
                            end else if (nextReady) begin
                                // Back-to-back frame, header on the next tick
                                state <= SER_WAIT;
                                curSel <= nextSel;
                                pending <= pending && frameReady;
                            end else begin
                                state <= SER_IDLE;
                            end
                        end
                    end
                    default: state <= SER_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SER_WAIT && bitTick) begin
            headerSr.raw <= {freshHeader.raw[hdrBits-2:0], 1'b0};
        end else if (state == SER_HEADER && bitTick) begin
            headerSr.raw <= {headerSr.raw[hdrBits-2:0], 1'b0};
        end
    end

    always_comb begin
        serialOut = '0;
        pingRd = 1'b0;
        pongRd = 1'b0;
        case (state)
            SER_WAIT: begin
                serialOut.bitEn = bitTick;
                serialOut.startOfFrame = bitTick;
                serialOut.bitVal = freshHeader.raw[hdrBits-1];
            end
            SER_HEADER: begin
                serialOut.bitEn = bitTick;
                serialOut.bitVal = headerSr.raw[hdrBits-1];
            end
            SER_PAYLOAD: begin
                serialOut.bitEn = bitTick;
                serialOut.bitVal = curHead;
                pingRd = bitTick && (curSel == PING);
                pongRd = bitTick && (curSel == PONG);
            end
            default: serialOut = '0;
        endcase
    end

endmodule

// ==== dqmFramerTop.sv ====
`timescale 1ns/1ps

module dqmFramerTop
    import dqmFramePkg::*, dqmBusPkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  wbReqT         wbReq,
    output wbRspT         wbRsp,
    input  payloadStreamT payloadIn,
    output serialStreamT  serialOut
);

    cfgT           cfg;
    logic          overrunPulse;
    payloadStreamT pingWr;
    payloadStreamT pongWr;
    logic          pingEmpty;
    logic          pongEmpty;
    logic          pingHead;
    logic          pongHead;
    logic          pingRd;
    logic          pongRd;
    logic          frameReady;
    bufSelT        readSel;
    logic          bufFlush;

    // Buffers are cleared whenever framing is disabled
    assign bufFlush = !cfg.enable;

    dqmRegs dqmRegs_i (
        .clk          (clk),
        .reset        (reset),
        .wbReq        (wbReq),
        .wbRsp        (wbRsp),
        .overrunPulse (overrunPulse),
        .cfg          (cfg)
    );

    dqmPayloadWriter dqmPayloadWriter_i (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg),
        .payloadIn    (payloadIn),
        .pingEmpty    (pingEmpty),
        .pongEmpty    (pongEmpty),
        .pingWr       (pingWr),
        .pongWr       (pongWr),
        .frameReady   (frameReady),
        .readSel      (readSel),
        .overrunPulse (overrunPulse)
    );

    dqmPingPongBuffer dqmPingPongBuffer_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (bufFlush),
        .pingWr    (pingWr),
        .pongWr    (pongWr),
        .pingRd    (pingRd),
        .pongRd    (pongRd),
        .pingHead  (pingHead),
        .pongHead  (pongHead),
        .pingEmpty (pingEmpty),
        .pongEmpty (pongEmpty)
    );

    dqmFrameSerializer dqmFrameSerializer_i (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .frameReady (frameReady),
        .readSel    (readSel),
        .pingHead   (pingHead),
        .pongHead   (pongHead),
        .pingEmpty  (pingEmpty),
        .pongEmpty  (pongEmpty),
        .pingRd     (pingRd),
        .pongRd     (pongRd),
        .serialOut  (serialOut)
    );

endmodule

// ==== dqmFramerSva.sv ====
`timescale 1ns/1ps

module dqmFramerSva
    import dqmFramePkg::*;
(
    input logic          clk,
    input logic          reset,
    input serStateT      serState,
    input serialStreamT  serialOut,
    input payloadStreamT pingWr,
    input payloadStreamT pongWr,
    input logic          pingRd,
    input logic          pongRd,
    input logic          pingEmpty,
    input logic          pongEmpty
);

    idleQuiet: assert property (@(posedge clk) disable iff (reset)
        serState == SER_IDLE |-> !serialOut.bitEn)
        else $error("serializer sent a bit while idle");

    // A buffer is never filled and drained in the same cycle
    pingWrRd: assert property (@(posedge clk) disable iff (reset) !(pingWr.bitEn && pingRd))
        else $error("ping written while read");
    pongWrRd: assert property (@(posedge clk) disable iff (reset) !(pongWr.bitEn && pongRd))
        else $error("pong written while read");

    pingRdEmpty: assert property (@(posedge clk) disable iff (reset) pingRd |-> !pingEmpty)
        else $error("read from empty ping buffer");
    pongRdEmpty: assert property (@(posedge clk) disable iff (reset) pongRd |-> !pongEmpty)
        else $error("read from empty pong buffer");

    sofWithBit: assert property (@(posedge clk) disable iff (reset)
        serialOut.startOfFrame |-> serialOut.bitEn)
        else $error("startOfFrame without bitEn");

endmodule

bind dqmFramerTop dqmFramerSva dqmFramerSva_i (
    .clk       (clk),
    .reset     (reset),
    .serState  (dqmFrameSerializer_i.state),
    .serialOut (serialOut),
    .pingWr    (pingWr),
    .pongWr    (pongWr),
    .pingRd    (pingRd),
    .pongRd    (pongRd),
    .pingEmpty (pingEmpty),
    .pongEmpty (pongEmpty)
);

// ==== dqmFramerTb.sv ====
`timescale 1ns/1ps
`include "dqmFramer_defines.svh"

module dqmFramerTb
    import dqmFramePkg::*, dqmBusPkg::*;
();

    localparam int hdrBits = `DQM_HDR_BITS;
    localparam int waitLimit = 20000;

    logic          clk;
    logic          reset;
    wbReqT         wbReq;
    wbRspT         wbRsp;
    payloadStreamT payloadIn;
    serialStreamT  serialOut;

    int          seed = 32'h482481e0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    longint      cycle = 0;
    longint      ackCycle = 0;
    int          payloadPeriod = 16;
    int          curLen = 24;
    int          expDiv = 3;
    logic [15:0] dqmOld = 16'hA5C3;
    logic [15:0] dqmNew = 16'hA5C3;
    longint      dqmChangeCycle = 0;
    logic        sentBits[$];
    logic        rxBits[$];
    bit          inFrame = 0;
    bit          resync = 1;
    bit          allowGap = 0;
    int          lastEnd = 0;
    longint      frameStart = 0;
    longint      lastBitCycle = 0;
    int          frameCount = 0;

    dqmFramerTop dqmFramerTop_i (
        .clk       (clk),
        .reset     (reset),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp),
        .payloadIn (payloadIn),
        .serialOut (serialOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle++;

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkHeader(input dqmHeaderT got, input dqmHeaderT exp);
        if (got.raw !== exp.raw) begin
            valueErrors++;
            $display("ERR header got 0x%012h expected 0x%012h", got.raw, exp.raw);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic wbAccess(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdData);
        int waited;
        waited = 0;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hF};
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wbRsp.ack && waited < 100);
        rdData = wbRsp.dat;
        ackCycle = cycle;
        if (!wbRsp.ack) begin
            otherErrors++;
            $display("Wishbone access to address %0h got no ack", adr);
        end
        // Request still held, ack must drop for one clock
        @(posedge clk);
        #2;
        if (wbRsp.ack) begin
            otherErrors++;
            $display("Wishbone access to address %0h got a second ack", adr);
        end
        wbReq = '0;
    endtask

    task automatic wbWrite(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [3:0] adr, output logic [31:0] dat);
        wbAccess(1'b0, adr, 32'h0, dat);
    endtask

    task automatic expectReg(input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] got;
        wbRead(adr, got);
        checkWord($sformatf("wbRsp.dat[%0h]", adr), got, exp);
    endtask

    // Payload source, one random bit every payloadPeriod clocks
    initial begin
        logic [31:0] r;
        payloadIn = '0;
        forever begin
            repeat (payloadPeriod - 1) @(posedge clk);
            #2;
            r = $random(seed);
            payloadIn = '{bitEn: 1'b1, bitVal: r[0]};
            sentBits.push_back(r[0]);
            @(posedge clk);
            #2;
            payloadIn = '0;
        end
    end

    function automatic int findRun(input int from);
        bit match;
        for (int s = from; s + curLen <= sentBits.size(); s++) begin
            match = 1;
            for (int i = 0; i < curLen; i++) begin
                if (sentBits[s + i] !== rxBits[hdrBits + i]) match = 0;
            end
            if (match) return s;
        end
        return -1;
    endfunction

    task automatic checkFrame();
        dqmHeaderT got;
        dqmHeaderT expHdr;
        int        start;
        expHdr.fields.sync = `DQM_SYNC_WORD;
        expHdr.fields.reserved = '0;
        expHdr.fields.version = `DQM_VERSION;
        expHdr.fields.dqm = (frameStart >= dqmChangeCycle) ? dqmNew : dqmOld;
        got.raw = '0;
        for (int i = 0; i < hdrBits; i++) begin
            got.raw = {got.raw[hdrBits-2:0], rxBits[i]};
        end
        checkHeader(got, expHdr);
        start = (resync || allowGap) ? findRun(lastEnd) : lastEnd;
        if (start < 0 || start + curLen > sentBits.size()) begin
            otherErrors++;
            $display("Frame payload is not a run of the input bits");
        end else begin
            for (int i = 0; i < curLen; i++) begin
                checkBit("serialOut.bitVal", rxBits[hdrBits + i], sentBits[start + i]);
            end
            lastEnd = start + curLen;
        end
        resync = 0;
        frameCount++;
    endtask

    // Serial decoder, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && serialOut.bitEn) begin
            if (serialOut.startOfFrame) begin
                inFrame = 1;
                rxBits.delete();
                frameStart = cycle;
            end else if (inFrame) begin
                checkWord("bitEn spacing", 32'(cycle - lastBitCycle), expDiv + 1);
            end
            if (inFrame) begin
                rxBits.push_back(serialOut.bitVal);
                lastBitCycle = cycle;
                if (rxBits.size() == hdrBits + curLen) begin
                    checkFrame();
                    inFrame = 0;
                end
            end
        end
    end

    task automatic waitFrames(input int n);
        int target;
        int waited;
        target = frameCount + n;
        waited = 0;
        while (frameCount < target && waited < waitLimit) begin
            @(posedge clk);
            waited++;
        end
        #2;
        if (frameCount < target) begin
            otherErrors++;
            $display("Timed out waiting for serial frames");
        end
    endtask

    task automatic registerReadback();
        wbWrite(REG_LENGTH, 32'd24);
        expectReg(REG_LENGTH, 32'd24);
        wbWrite(REG_DIVIDER, 32'd3);
        expectReg(REG_DIVIDER, 32'd3);
        wbWrite(REG_DQM, 32'h0000_A5C3);
        expectReg(REG_DQM, 32'h0000_A5C3);
        wbWrite(REG_CTRL, 32'd1);
        expectReg(REG_CTRL, 32'd1);
        wbWrite(REG_CTRL, 32'd0);
        expectReg(REG_CTRL, 32'd0);
        wbWrite(4'h9, 32'hFFFF_FFFF);
        expectReg(4'h9, 32'h0);
        expectReg(REG_OVERRUN, 32'h0);
    endtask

    task automatic framingAtRate(input int div, input int period, input int frames);
        wbWrite(REG_CTRL, 32'd0);
        expDiv = div;
        payloadPeriod = period;
        wbWrite(REG_DIVIDER, div);
        resync = 1;
        wbWrite(REG_CTRL, 32'd1);
        waitFrames(frames);
    endtask

    task automatic dqmMidStream();
        dqmNew = 16'h3C5A;
        dqmChangeCycle = 64'h7FFF_FFFF_FFFF_FFFF;
        repeat (100) @(posedge clk);
        #2;
        wbWrite(REG_DQM, 32'h0000_3C5A);
        dqmChangeCycle = ackCycle;
        waitFrames(3);
        dqmOld = dqmNew;
    endtask

    task automatic overrunRecovery();
        int          polls;
        logic [31:0] count;
        allowGap = 1;
        payloadPeriod = 2;
        polls = 0;
        count = 0;
        while (count == 0 && polls < 200) begin
            repeat (50) @(posedge clk);
            #2;
            wbRead(REG_OVERRUN, count);
            polls++;
        end
        if (count == 0) begin
            otherErrors++;
            $display("Overrun counter stayed at zero with fast input");
        end
        payloadPeriod = 32;
        waitFrames(4);
    endtask

    initial begin
        reset = 1'b1;
        wbReq = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        registerReadback();
        framingAtRate(3, 16, 5);
        framingAtRate(7, 32, 3);
        dqmMidStream();
        overrunRecovery();
        $display("Summary: %0d value errors, %0d other errors, %0d frames checked",
                 valueErrors, otherErrors, frameCount);
        if (valueErrors + otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
dqmFramePkg.sv
dqmBusPkg.sv
dqmRegs.sv
dqmPayloadWriter.sv
dqmPingPongBuffer.sv
dqmFrameSerializer.sv
dqmFramerTop.sv
dqmFramerSva.sv
dqmFramerTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module dqmFramerTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
